//--- Makefile
VERILATOR ?= verilator
TOP       ?= usb_packet_sender_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' vlog.f)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): vlog.f $(SRCS)
	$(VERILATOR) $(VFLAGS) -f vlog.f --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/usb_bit_stuffer.sv
`timescale 1ns/1ps
`default_nettype none

module usb_bit_stuffer (
  input  logic                    clock,
  input  logic                    reset_n,
  input  usb_tx_pkg::serial_bit_t crc5_in,
  input  usb_tx_pkg::serial_bit_t crc16_in,
  input  logic                    line_ready,
  output logic                    stuff_ready,
  output usb_tx_pkg::serial_bit_t out
);

  logic [2:0] ones_cnt;
  logic       in_valid;
  logic       in_value;
  logic       stuff_now;

  // only one encoder is active at a time
  assign in_valid = crc5_in.valid | crc16_in.valid;
  assign in_value = crc5_in.valid ? crc5_in.value : crc16_in.value;

  // six ones seen, a zero goes out next
  assign stuff_now = (ones_cnt == 3'(usb_tx_pkg::STUFF_LIMIT));

  // hold the encoders while stuffing or while the line is busy with sync
  assign stuff_ready = line_ready & ~stuff_now;

  // stuffed zero may trail the last packet bit
  assign out.valid = in_valid | stuff_now;
  assign out.value = stuff_now ? 1'b0 : in_value;

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      ones_cnt <= '0;
    end else if (line_ready) begin
      if (stuff_now) begin
        ones_cnt <= '0;
      end else if (in_valid) begin
        // count the run of ones, a zero breaks it
        if (in_value) begin
          ones_cnt <= ones_cnt + 1'b1;
        end else begin
          ones_cnt <= '0;
        end
      end else begin
        // packet over
        ones_cnt <= '0;
      end
    end
  end

  // both encoders talking at once means the top decoded two kinds
  a_one_source : assert property (
    @(posedge clock) disable iff (!reset_n) !(crc5_in.valid && crc16_in.valid)
  ) else $error("crc5 and crc16 streams valid together");

endmodule

`default_nettype wire

//--- hdl/usb_crc16_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module usb_crc16_encoder (
  input  logic                    clock,
  input  logic                    reset_n,
  input  logic                    load,
  input  usb_tx_pkg::pid_t        pid,
  input  usb_tx_pkg::payload_t    payload,
  input  logic                    stuff_ready,
  output usb_tx_pkg::serial_bit_t out
);

  typedef enum logic {IDLE, SEND} state_e;

  state_e                                   state;
  logic [usb_tx_pkg::DATA_FRAME_BITS-1:0]   frame;
  usb_tx_pkg::crc16_t                       crc;
  logic [6:0]                               bit_cnt;
  logic                                     in_frame;
  logic                                     last_bit;
  logic                                     advance;

  // serial crc16 step, one input bit
  function automatic usb_tx_pkg::crc16_t crc16_step(input usb_tx_pkg::crc16_t c,
                                                    input logic b);
    logic fb;
    fb = c[15] ^ b;
    return {c[14:0], 1'b0} ^ (fb ? usb_tx_pkg::CRC16_POLY : '0);
  endfunction

  // 72 frame bits then 16 crc bits
  assign in_frame = bit_cnt < 7'(usb_tx_pkg::DATA_FRAME_BITS);
  assign last_bit = bit_cnt == 7'(usb_tx_pkg::DATA_FRAME_BITS + usb_tx_pkg::CRC16_BITS - 1);
  assign advance  = (state == SEND) && stuff_ready;

  assign out.valid = (state == SEND);
  // complemented remainder, msb first
  assign out.value = in_frame ? frame[0] : ~crc[15];

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state   <= IDLE;
      bit_cnt <= '0;
    end else if (load) begin
      state   <= SEND;
      bit_cnt <= '0;
    end else if (advance) begin
      bit_cnt <= bit_cnt + 1'b1;
      if (last_bit) begin
        state <= IDLE;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      frame <= {payload, pid};
      crc   <= '1;
    end else if (advance) begin
      if (in_frame) begin
        frame <= frame >> 1;
        // crc runs over the payload bytes only
        if (bit_cnt >= 7'(usb_tx_pkg::PID_BITS)) begin
          crc <= crc16_step(crc, frame[0]);
        end
      end else begin
        crc <= crc << 1;
      end
    end
  end

  // top must not reload while a packet is still on its way out
  a_no_load_while_sending : assert property (
    @(posedge clock) disable iff (!reset_n) load |-> !out.valid
  ) else $error("crc16 encoder reloaded mid packet");

endmodule

`default_nettype wire

//--- hdl/usb_crc5_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module usb_crc5_encoder (
  input  logic                    clock,
  input  logic                    reset_n,
  input  logic                    load,
  input  usb_tx_pkg::pid_t        pid,
  input  usb_tx_pkg::addr_t       addr,
  input  usb_tx_pkg::endp_t       endp,
  input  logic                    stuff_ready,
  output usb_tx_pkg::serial_bit_t out
);

  typedef enum logic {IDLE, SEND} state_e;

  state_e                                    state;
  logic [usb_tx_pkg::TOKEN_FRAME_BITS-1:0]   frame;
  usb_tx_pkg::crc5_t                         crc;
  logic [4:0]                                bit_cnt;
  logic                                      in_frame;
  logic                                      last_bit;
  logic                                      advance;

  // serial crc5 step, one input bit
  function automatic usb_tx_pkg::crc5_t crc5_step(input usb_tx_pkg::crc5_t c, input logic b);
    logic fb;
    fb = c[4] ^ b;
    return {c[3:0], 1'b0} ^ (fb ? usb_tx_pkg::CRC5_POLY : '0);
  endfunction

  // frame bits first, crc bits after
  assign in_frame = bit_cnt < 5'(usb_tx_pkg::TOKEN_FRAME_BITS);
  assign last_bit = bit_cnt == 5'(usb_tx_pkg::TOKEN_FRAME_BITS + usb_tx_pkg::CRC5_BITS - 1);
  assign advance  = (state == SEND) && stuff_ready;

  // inverted crc goes out msb first
  assign out.valid = (state == SEND);
  assign out.value = in_frame ? frame[0] : ~crc[4];

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state   <= IDLE;
      bit_cnt <= '0;
    end else if (load) begin
      state   <= SEND;
      bit_cnt <= '0;
    end else if (advance) begin
      bit_cnt <= bit_cnt + 1'b1;
      if (last_bit) begin
        state <= IDLE;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      frame <= {endp, addr, pid};
      crc   <= '1;
    end else if (advance) begin
      if (in_frame) begin
        frame <= frame >> 1;
        // pid is not covered by the crc
        if (bit_cnt >= 5'(usb_tx_pkg::PID_BITS)) begin
          crc <= crc5_step(crc, frame[0]);
        end
      end else begin
        crc <= crc << 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/usb_handshake_sender.sv
`timescale 1ns/1ps
`default_nettype none

module usb_handshake_sender (
  input  logic                    clock,
  input  logic                    reset_n,
  input  logic                    start,
  input  usb_tx_pkg::pid_t        pid,
  output usb_tx_pkg::serial_bit_t out
);

  typedef enum logic [1:0] {IDLE, WAIT_SYNC, SEND} state_e;

  state_e           state;
  usb_tx_pkg::pid_t shreg;
  logic [3:0]       bit_cnt;
  logic             sync_done;
  logic             pid_done;
  logic             load;
  logic             shift;

  assign sync_done = bit_cnt == 4'(usb_tx_pkg::SYNC_LEN - 1);
  assign pid_done  = bit_cnt == 4'(usb_tx_pkg::PID_BITS);

  // fsm control
  assign load  = (state == IDLE) && start;
  assign shift = (state == SEND) && !pid_done;

  // valid during the wait too, so the line driver starts sync
  assign out.valid = (state == WAIT_SYNC) || shift;
  assign out.value = shreg[0];

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state   <= IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state   <= WAIT_SYNC;
            bit_cnt <= '0;
          end
        end
        WAIT_SYNC: begin
          // line driver owns these 8 cycles
          if (sync_done) begin
            state   <= SEND;
            bit_cnt <= '0;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        SEND: begin
          if (pid_done) begin
            state <= IDLE;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // right shifting piso, lsb leaves first
  always_ff @(posedge clock) begin
    if (load) begin
      shreg <= pid;
    end else if (shift) begin
      shreg <= shreg >> 1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/usb_line_driver.sv
`timescale 1ns/1ps
`default_nettype none

module usb_line_driver (
  input  logic                    clock,
  input  logic                    reset_n,
  input  usb_tx_pkg::serial_bit_t stuffed,
  input  usb_tx_pkg::serial_bit_t hs_bit,
  output logic                    line_ready,
  output logic                    dp,
  output logic                    dm,
  output logic                    sent
);

  typedef enum logic [2:0] {IDLE, SYNC, DATA, SE0, EOP_J} state_e;

  state_e     state;
  logic       level;
  logic [2:0] cnt;
  logic       in_valid;
  logic       in_value;

  // zero toggles the line, one holds it
  function automatic logic nrzi(input logic lvl, input logic b);
    return b ? lvl : ~lvl;
  endfunction

  assign in_valid = stuffed.valid | hs_bit.valid;
  assign in_value = stuffed.valid ? stuffed.value : hs_bit.value;

  // upstream may only move while data bits are on the line
  assign line_ready = (state == DATA);

  // se0 pulls both lines low, otherwise differential
  assign dp = (state == SE0) ? 1'b0 : level;
  assign dm = (state == SE0) ? 1'b0 : ~level;

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state <= IDLE;
      level <= 1'b1;
      cnt   <= '0;
      sent  <= 1'b0;
    end else begin
      sent <= 1'b0;
      case (state)
        IDLE: begin
          // first sync bit goes out on the edge that sees valid
          if (in_valid) begin
            level <= nrzi(level, usb_tx_pkg::SYNC_BITS[0]);
            cnt   <= 3'd1;
            state <= SYNC;
          end
        end
        SYNC: begin
          level <= nrzi(level, usb_tx_pkg::SYNC_BITS[cnt]);
          cnt   <= cnt + 1'b1;
          if (cnt == 3'(usb_tx_pkg::SYNC_LEN - 1)) begin
            state <= DATA;
          end
        end
        DATA: begin
          if (in_valid) begin
            level <= nrzi(level, in_value);
          end else begin
            // source went quiet, start end of packet
            state <= SE0;
            cnt   <= '0;
          end
        end
        SE0: begin
          cnt <= cnt + 1'b1;
          if (cnt == 3'(usb_tx_pkg::EOP_SE0_BITS - 1)) begin
            state <= EOP_J;
            level <= 1'b1;
          end
        end
        EOP_J: begin
          // one j bit, then back to idle
          state <= IDLE;
          sent  <= 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // stuffer path and handshake path never overlap
  a_single_source : assert property (
    @(posedge clock) disable iff (!reset_n) !(stuffed.valid && hs_bit.valid)
  ) else $error("stuffed and handshake bits valid together");

endmodule

`default_nettype wire

//--- hdl/usb_packet_sender.sv
`timescale 1ns/1ps
`default_nettype none

module usb_packet_sender (
  input  logic                clock,
  input  logic                reset_n,
  input  usb_tx_pkg::tx_cmd_t cmd,
  input  logic                cmd_valid,
  output logic                busy,
  output logic                dp,
  output logic                dm,
  output logic                sent
);

  usb_tx_pkg::tx_cmd_t     cmd_q;
  usb_tx_pkg::pid_t        token_pid;
  usb_tx_pkg::pid_t        hs_pid;
  usb_tx_pkg::serial_bit_t token_bit;
  usb_tx_pkg::serial_bit_t data_bit;
  usb_tx_pkg::serial_bit_t stuffed;
  usb_tx_pkg::serial_bit_t hs_bit;
  logic                    busy_q;
  logic                    accept;
  logic                    token_load;
  logic                    data_load;
  logic                    hs_start;
  logic                    stuff_ready;
  logic                    line_ready;

  // busy drops together with sent
  assign busy   = busy_q & ~sent;
  assign accept = cmd_valid & ~busy;

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      busy_q     <= 1'b0;
      token_load <= 1'b0;
      data_load  <= 1'b0;
      hs_start   <= 1'b0;
    end else begin
      // one load strobe per block, a cycle after acceptance
      token_load <= accept && (cmd.kind == usb_tx_pkg::CMD_OUT ||
                               cmd.kind == usb_tx_pkg::CMD_IN);
      data_load  <= accept && (cmd.kind == usb_tx_pkg::CMD_DATA0);
      hs_start   <= accept && (cmd.kind == usb_tx_pkg::CMD_ACK ||
                               cmd.kind == usb_tx_pkg::CMD_NAK);
      if (accept) begin
        busy_q <= 1'b1;
      end else if (sent) begin
        busy_q <= 1'b0;
      end
    end
  end

  // command word held for the block loads
  always_ff @(posedge clock) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

  // pid by command kind
  always_comb begin
    token_pid = (cmd_q.kind == usb_tx_pkg::CMD_IN)  ? usb_tx_pkg::PID_IN  : usb_tx_pkg::PID_OUT;
    hs_pid    = (cmd_q.kind == usb_tx_pkg::CMD_NAK) ? usb_tx_pkg::PID_NAK : usb_tx_pkg::PID_ACK;
  end

  usb_crc5_encoder crc5_enc_i (
    .clock       (clock),
    .reset_n     (reset_n),
    .load        (token_load),
    .pid         (token_pid),
    .addr        (usb_tx_pkg::DEVICE_ADDR),
    .endp        (cmd_q.endp),
    .stuff_ready (stuff_ready),
    .out         (token_bit)
  );

  usb_crc16_encoder crc16_enc_i (
    .clock       (clock),
    .reset_n     (reset_n),
    .load        (data_load),
    .pid         (usb_tx_pkg::PID_DATA0),
    .payload     (cmd_q.payload),
    .stuff_ready (stuff_ready),
    .out         (data_bit)
  );

  usb_bit_stuffer stuffer_i (
    .clock       (clock),
    .reset_n     (reset_n),
    .crc5_in     (token_bit),
    .crc16_in    (data_bit),
    .line_ready  (line_ready),
    .stuff_ready (stuff_ready),
    .out         (stuffed)
  );

  // handshakes skip crc and stuffing
  usb_handshake_sender hs_i (
    .clock   (clock),
    .reset_n (reset_n),
    .start   (hs_start),
    .pid     (hs_pid),
    .out     (hs_bit)
  );

  usb_line_driver line_i (
    .clock      (clock),
    .reset_n    (reset_n),
    .stuffed    (stuffed),
    .hs_bit     (hs_bit),
    .line_ready (line_ready),
    .dp         (dp),
    .dm         (dm),
    .sent       (sent)
  );

  // a strobe during a packet is dropped
  a_cmd_while_busy : assert property (
    @(posedge clock) disable iff (!reset_n) !(cmd_valid && busy)
  ) else $warning("cmd_valid while busy, command dropped");

endmodule

`default_nettype wire

//--- hdl/usb_tx_pkg.sv
`default_nettype none

package usb_tx_pkg;

  // packet identifier, sent lsb first
  typedef logic [7:0]  pid_t;
  typedef logic [3:0]  endp_t;
  typedef logic [6:0]  addr_t;
  // byte 0 sits in the low bits
  typedef logic [63:0] payload_t;
  typedef logic [4:0]  crc5_t;
  typedef logic [15:0] crc16_t;

  typedef enum logic [2:0] {
    CMD_OUT,
    CMD_IN,
    CMD_DATA0,
    CMD_ACK,
    CMD_NAK
  } cmd_kind_e;

  // command word handed to the top level
  typedef struct packed {
    cmd_kind_e kind;
    endp_t     endp;
    payload_t  payload;
  } tx_cmd_t;

  // one bit on a link between blocks
  typedef struct packed {
    logic valid;
    logic value;
  } serial_bit_t;

  // upper nibble is the complement of the lower nibble
  localparam pid_t PID_OUT   = 8'hE1;
  localparam pid_t PID_IN    = 8'h69;
  localparam pid_t PID_DATA0 = 8'hC3;
  localparam pid_t PID_ACK   = 8'hD2;
  localparam pid_t PID_NAK   = 8'h5A;

  localparam addr_t DEVICE_ADDR = 7'd5;

  // seven zeros then a one, lsb first
  localparam logic [7:0] SYNC_BITS = 8'b1000_0000;
  localparam int SYNC_LEN     = $bits(SYNC_BITS);
  localparam int STUFF_LIMIT  = 6;
  localparam int EOP_SE0_BITS = 2;

  // frame sizes ahead of the crc
  localparam int PID_BITS         = $bits(pid_t);
  localparam int TOKEN_FRAME_BITS = PID_BITS + $bits(addr_t) + $bits(endp_t);
  localparam int DATA_FRAME_BITS  = PID_BITS + $bits(payload_t);
  localparam int CRC5_BITS        = $bits(crc5_t);
  localparam int CRC16_BITS       = $bits(crc16_t);

  // x^5 + x^2 + 1 and x^16 + x^15 + x^2 + 1
  localparam crc5_t  CRC5_POLY  = 5'b00101;
  localparam crc16_t CRC16_POLY = 16'h8005;

  // remainder left when a receiver runs the crc over data plus crc
  localparam crc5_t  CRC5_RESIDUAL  = 5'b01100;
  localparam crc16_t CRC16_RESIDUAL = 16'h800D;

endpackage

`default_nettype wire

//--- tb/usb_packet_sender_tb.sv
`timescale 1ns/1ps
`default_nettype none

module usb_packet_sender_tb;

  localparam int CLK_PERIOD      = 40;
  localparam int DRIVE_DELAY     = 2;
  localparam int RESET_CYCLES    = 4;
  localparam int CYCLES_PER_LINE = 200;
  // room for a dropped nak to surface as a whole packet
  localparam int SETTLE_CYCLES   = 40;

  // monitor phases while decoding the line
  typedef enum int {M_IDLE, M_BITS, M_SE0, M_EOP_J, M_AFTER} mon_state_e;

  logic                clock;
  logic                reset_n;
  usb_tx_pkg::tx_cmd_t cmd;
  logic                cmd_valid;
  logic                busy;
  logic                dp;
  logic                dm;
  logic                sent;

  // one entry per stimulus line
  usb_tx_pkg::cmd_kind_e kind_q[$];
  usb_tx_pkg::endp_t     endp_q[$];
  usb_tx_pkg::payload_t  payload_q[$];
  logic [15:0]           crc_q[$];
  int                    strobes_q[$];
  int                    pkts_q[$];

  int         seed;
  int         cycles;
  int         timeout_limit;
  int         pkt_count;
  mon_state_e mon_state;
  logic       prev_level;
  int         se0_cnt;
  logic       raw_bits[$];
  logic       pkt_bits[$];

  usb_packet_sender dut_i (
    .clock     (clock),
    .reset_n   (reset_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .busy      (busy),
    .dp        (dp),
    .dm        (dm),
    .sent      (sent)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_pid(input usb_tx_pkg::pid_t got, input usb_tx_pkg::pid_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("ERR %0t: pid got %h expected %h", $time, got, exp));
  endtask

  task automatic check_endp(input usb_tx_pkg::endp_t got, input usb_tx_pkg::endp_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("ERR %0t: endp got %h expected %h", $time, got, exp));
  endtask

  task automatic check_addr(input usb_tx_pkg::addr_t got, input usb_tx_pkg::addr_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("ERR %0t: addr got %h expected %h", $time, got, exp));
  endtask

  task automatic check_payload(input usb_tx_pkg::payload_t got,
                               input usb_tx_pkg::payload_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("ERR %0t: payload got %h expected %h", $time, got, exp));
  endtask

  task automatic check_crc5(input usb_tx_pkg::crc5_t got, input usb_tx_pkg::crc5_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("ERR %0t: crc5 got %h expected %h", $time, got, exp));
  endtask

  task automatic check_crc16(input usb_tx_pkg::crc16_t got, input usb_tx_pkg::crc16_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("ERR %0t: crc16 got %h expected %h", $time, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      stop_with_failure($sformatf("ERR %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  // field from the destuffed bits, first bit on the wire is the lsb
  function automatic logic [63:0] field_bits(input int first, input int width);
    logic [63:0] v;
    v = '0;
    for (int j = 0; j < width; j++) begin
      v[j] = pkt_bits[first + j];
    end
    return v;
  endfunction

  // strip sync, then drop the zero after every run of six ones
  task automatic destuff_packet;
    int         ones;
    logic [7:0] sync;
    if (raw_bits.size() < 8) stop_with_failure("packet ended before a full sync field");
    for (int j = 0; j < 8; j++) begin
      sync[j] = raw_bits[j];
    end
    if (sync !== usb_tx_pkg::SYNC_BITS)
      stop_with_failure($sformatf("ERR %0t: sync got %b expected %b", $time, sync,
                                  usb_tx_pkg::SYNC_BITS));
    pkt_bits.delete();
    ones = 0;
    for (int j = 8; j < raw_bits.size(); j++) begin
      if (ones == usb_tx_pkg::STUFF_LIMIT) begin
        if (raw_bits[j]) stop_with_failure("a one followed six ones, stuffed zero missing");
        ones = 0;
      end else begin
        pkt_bits.push_back(raw_bits[j]);
        ones = raw_bits[j] ? ones + 1 : 0;
      end
    end
    if (ones == usb_tx_pkg::STUFF_LIMIT)
      stop_with_failure("packet ended on six ones without a stuffed zero");
  endtask

  // line monitor, samples mid cycle
  always @(negedge clock) begin
    if (reset_n) begin
      if (dp && dm) stop_with_failure("dp and dm both high, illegal line state");
      case (mon_state)
        M_IDLE: begin
          if (sent) stop_with_failure("sent pulsed with no packet on the line");
          if (!dp && !dm) begin
            stop_with_failure("SE0 seen outside a packet");
          end else if (!dp) begin
            // first j to k step is the first sync zero
            raw_bits.delete();
            raw_bits.push_back(1'b0);
            prev_level = 1'b0;
            mon_state  = M_BITS;
          end
        end
        M_BITS: begin
          if (!dp && !dm) begin
            se0_cnt   = 1;
            mon_state = M_SE0;
          end else begin
            // nrzi, unchanged level is a one
            raw_bits.push_back(dp == prev_level);
            prev_level = dp;
          end
        end
        M_SE0: begin
          if (!dp && !dm) begin
            se0_cnt++;
          end else begin
            if (se0_cnt != usb_tx_pkg::EOP_SE0_BITS)
              stop_with_failure($sformatf("end of packet held SE0 for %0d samples, not 2",
                                          se0_cnt));
            if (!dp) stop_with_failure("end of packet SE0 not followed by J");
            if (sent) stop_with_failure("sent pulsed before the J bit of the end of packet");
            mon_state = M_EOP_J;
          end
        end
        M_EOP_J: begin
          if (!dp) stop_with_failure("line left J right after the end of packet");
          if (sent !== 1'b1) stop_with_failure("sent did not pulse on the step from J to idle");
          destuff_packet();
          pkt_count++;
          mon_state = M_AFTER;
        end
        M_AFTER: begin
          if (sent) stop_with_failure("sent stayed high for more than one cycle");
          if (busy) stop_with_failure("busy still high the cycle after sent");
          mon_state = M_IDLE;
        end
        default: mon_state = M_IDLE;
      endcase
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > timeout_limit)
      stop_with_failure($sformatf("timeout, run still going after %0d cycles", cycles));
  end

  task automatic send_command(input usb_tx_pkg::tx_cmd_t c);
    @(posedge clock);
    #DRIVE_DELAY;
    cmd       = c;
    cmd_valid = 1'b1;
    @(posedge clock);
    #DRIVE_DELAY;
    cmd_valid = 1'b0;
  endtask

  task automatic check_packet(input int i);
    usb_tx_pkg::pid_t exp_pid;
    int               exp_len;
    case (kind_q[i])
      usb_tx_pkg::CMD_OUT: begin
        exp_pid = usb_tx_pkg::PID_OUT;
        exp_len = 24;
      end
      usb_tx_pkg::CMD_IN: begin
        exp_pid = usb_tx_pkg::PID_IN;
        exp_len = 24;
      end
      usb_tx_pkg::CMD_DATA0: begin
        exp_pid = usb_tx_pkg::PID_DATA0;
        exp_len = 88;
      end
      usb_tx_pkg::CMD_ACK: begin
        exp_pid = usb_tx_pkg::PID_ACK;
        exp_len = 8;
      end
      default: begin
        exp_pid = usb_tx_pkg::PID_NAK;
        exp_len = 8;
      end
    endcase
    if (pkt_bits.size() != exp_len)
      stop_with_failure($sformatf("line %0d decoded %0d packet bits, expected %0d",
                                  i, pkt_bits.size(), exp_len));
    check_pid(usb_tx_pkg::pid_t'(field_bits(0, 8)), exp_pid);
    if (exp_len == 24) begin
      check_addr(usb_tx_pkg::addr_t'(field_bits(8, 7)), usb_tx_pkg::DEVICE_ADDR);
      check_endp(usb_tx_pkg::endp_t'(field_bits(15, 4)), endp_q[i]);
      check_crc5(usb_tx_pkg::crc5_t'(field_bits(19, 5)), usb_tx_pkg::crc5_t'(crc_q[i]));
    end else if (exp_len == 88) begin
      check_payload(field_bits(8, 64), payload_q[i]);
      check_crc16(usb_tx_pkg::crc16_t'(field_bits(72, 16)), crc_q[i]);
    end
  endtask

  initial begin
    int                  fd;
    string               line;
    int                  k;
    logic [3:0]          e;
    logic [63:0]         p;
    logic [15:0]         c;
    int                  s;
    int                  x;
    int                  gap;
    int                  start_count;
    usb_tx_pkg::tx_cmd_t next_cmd;
    usb_tx_pkg::tx_cmd_t ghost;
    reset_n       = 1'b0;
    cmd_valid     = 1'b0;
    cmd           = '0;
    seed          = 43;
    cycles        = 0;
    pkt_count     = 0;
    timeout_limit = 100;
    mon_state     = M_IDLE;
    prev_level    = 1'b1;
    se0_cnt       = 0;

    fd = $fopen("tb/usb_tx_stimulus.txt", "r");
    if (fd == 0) stop_with_failure("could not open tb/usb_tx_stimulus.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      if ($sscanf(line, "%h %h %h %h %d %d", k, e, p, c, s, x) != 6 || k > 4)
        stop_with_failure($sformatf("bad stimulus line: %s", line));
      kind_q.push_back(usb_tx_pkg::cmd_kind_e'(k));
      endp_q.push_back(e);
      payload_q.push_back(p);
      crc_q.push_back(c);
      strobes_q.push_back(s);
      pkts_q.push_back(x);
    end
    $fclose(fd);
    timeout_limit = kind_q.size() * CYCLES_PER_LINE + 100;

    repeat (RESET_CYCLES) @(posedge clock);
    #DRIVE_DELAY;
    reset_n = 1'b1;
    @(negedge clock);
    check_bit(dp, 1'b1, "dp after reset");
    check_bit(dm, 1'b0, "dm after reset");
    check_bit(busy, 1'b0, "busy after reset");
    check_bit(sent, 1'b0, "sent after reset");

    for (int i = 0; i < kind_q.size(); i++) begin
      gap = $unsigned($random(seed)) % 8;
      repeat (gap) @(posedge clock);
      start_count      = pkt_count;
      next_cmd.kind    = kind_q[i];
      next_cmd.endp    = endp_q[i];
      next_cmd.payload = payload_q[i];
      send_command(next_cmd);
      if (strobes_q[i] > 1) begin
        // strobe while busy, must be dropped
        ghost      = '0;
        ghost.kind = usb_tx_pkg::CMD_NAK;
        repeat (3) @(posedge clock);
        send_command(ghost);
      end
      while (pkt_count == start_count) @(posedge clock);
      check_packet(i);
      repeat (SETTLE_CYCLES) @(posedge clock);
      if (pkt_count != start_count + pkts_q[i])
        stop_with_failure($sformatf("line %0d produced %0d packets, expected %0d",
                                    i, pkt_count - start_count, pkts_q[i]));
      if (busy) stop_with_failure("busy high with no command pending");
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/usb_tx_stimulus.txt
# kind endp payload crc strobes pkts (kind 0 out, 1 in, 2 data0, 3 ack, 4 nak)
# endp, payload and crc in hex, crc as sent lsb first; strobes and pkts in decimal
0 1 0000000000000000 000c 1 1
1 2 0000000000000000 001f 1 1
0 0 0000000000000000 001a 1 1
2 0 ffffffffffffffff 70fe 1 1
3 0 0000000000000000 0000 1 1
4 0 0000000000000000 0000 1 1
2 0 000000000000ffff ffff 1 1
1 1 0000000000000000 000c 2 1
3 0 0000000000000000 0000 2 1
2 0 ffffffffffffffff 70fe 2 1
4 0 0000000000000000 0000 1 1
2 0 000000000000ffff ffff 1 1
0 2 0000000000000000 001f 2 1

//--- vlog.f
hdl/usb_tx_pkg.sv
hdl/usb_crc5_encoder.sv
hdl/usb_crc16_encoder.sv
hdl/usb_bit_stuffer.sv
hdl/usb_handshake_sender.sv
hdl/usb_line_driver.sv
hdl/usb_packet_sender.sv
tb/usb_packet_sender_tb.sv
